/* project.f */
logic/io_map_pkg.sv
logic/periph_pkg.sv
logic/uart_port.sv
logic/spi_port.sv
logic/io_decoder.sv
logic/io_subsystem.sv
bench/io_subsystem_checker.sv
bench/io_subsystem_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = io_subsystem_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+100
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* bench/io_subsystem_tb.sv */
`timescale 1ns/1ns

module io_subsystem_tb;

  localparam io_map_pkg::addr_t uart_stat = io_map_pkg::uart_base + 11'd4;
  localparam io_map_pkg::addr_t spi_stat  = io_map_pkg::spi_base + 11'd4;

  logic              clk;
  logic              rst_n;
  logic              read;
  logic              write;
  io_map_pkg::addr_t address;
  io_map_pkg::word_t data_in;
  io_map_pkg::be_t   be;
  logic [15:0]       sw;
  logic [3:0]        kbd;
  logic              rx0;
  logic              miso;
  io_map_pkg::word_t data_out;
  logic              wait_out;
  logic              tx0;
  logic              sclk;
  logic              mosi;
  logic [7:0]        spi_selects;
  logic              interrupt;

  int                checks = 0;
  int                errors = 0;
  logic [31:0]       r;
  io_map_pkg::word_t got;
  periph_pkg::byte_t first_byte;
  logic [7:0]        sel;

  io_subsystem #(
    .clks_per_bit (8),
    .sclk_div     (2)
  ) i_dut (
    .clk(clk), .rst_n(rst_n), .read(read), .write(write), .address(address),
    .data_in(data_in), .be(be), .sw(sw), .kbd(kbd), .rx0(rx0), .miso(miso),
    .data_out(data_out), .wait_out(wait_out), .tx0(tx0), .sclk(sclk), .mosi(mosi),
    .spi_selects(spi_selects), .interrupt(interrupt)
  );

  assign rx0  = tx0;   // uart loopback
  assign miso = mosi;  // spi loopback

  always #20 clk = ~clk;

  // ########################################
  // bus access and checks
  // ########################################

  task automatic check_value(input string what, input io_map_pkg::word_t seen,
                             input io_map_pkg::word_t expected);
    checks++;
    assert (seen == expected) else begin
      errors++;
      $display("Error at %0t ns: %s read %h, expected %h", $time, what, seen, expected);
    end
  endtask

  // sample data_out in the clock where wait_out has dropped
  task automatic finish_access(output io_map_pkg::word_t sample);
    int n;
    n = 0;
    sample = '0;
    do begin
      @(negedge clk);
      n++;
    end while (wait_out && n < 8);
    if (wait_out) begin
      errors++;
      $display("bus access at %0t ns never saw wait_out go low", $time);
    end
    sample = data_out;
  endtask

  task automatic bus_read(input io_map_pkg::addr_t addr, output io_map_pkg::word_t rdata);
    @(posedge clk);
    read    <= 1'b1;
    address <= addr;
    finish_access(rdata);
    @(posedge clk);
    read <= 1'b0;
  endtask

  task automatic bus_write(input io_map_pkg::addr_t addr, input io_map_pkg::word_t wdata,
                           input io_map_pkg::be_t lanes);
    io_map_pkg::word_t unused;
    @(posedge clk);
    write   <= 1'b1;
    address <= addr;
    data_in <= wdata;
    be      <= lanes;
    finish_access(unused);
    @(posedge clk);
    write <= 1'b0;
  endtask

  task automatic poll_status(input io_map_pkg::addr_t addr, input int idx, input logic want,
                             input int limit, input string what);
    io_map_pkg::word_t st;
    int n;
    n = 0;
    bus_read(addr, st);
    while (st[idx] !== want && n < limit) begin
      bus_read(addr, st);
      n++;
    end
    if (st[idx] !== want) begin
      errors++;
      $display("gave up waiting for %s at %0t ns", what, $time);
    end
  endtask

  // ########################################
  // stimulus
  // ########################################

  initial begin
    void'($urandom(32'h2dfb));
    clk = 1'b0;
    rst_n = 1'b0;
    read = 1'b0;
    write = 1'b0;
    address = '0;
    data_in = '0;
    be = '0;
    sw = '0;
    kbd = 4'hf;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    for (int i = 0; i < 4; i++) begin
      r = $urandom;
      sw  <= r[15:0];
      kbd <= r[19:16];
      bus_read(io_map_pkg::input_base, got);
      check_value("switch/keypad word", got, {12'h000, ~r[19:16], r[15:0]});
    end
    bus_read(11'h030, got);
    check_value("unmapped address", got, '0);

    for (int i = 0; i < 4; i++) begin
      poll_status(uart_stat, periph_pkg::stat_busy, 1'b0, 100, "uart transmitter idle");
      r = $urandom;
      bus_write(io_map_pkg::uart_base, {24'h0, r[7:0]}, 4'b0001);
      poll_status(uart_stat, periph_pkg::stat_rx_valid, 1'b1, 100, "uart rx_valid");
      @(negedge clk);
      check_value("interrupt with byte waiting", {31'h0, interrupt}, 32'h1);
      bus_read(io_map_pkg::uart_base, got);
      check_value("uart loopback byte", got, {24'h0, r[7:0]});
      @(negedge clk);
      check_value("interrupt after data read", {31'h0, interrupt}, 32'h0);
    end

    // second byte lands while the first is on the line
    poll_status(uart_stat, periph_pkg::stat_busy, 1'b0, 100, "uart transmitter idle");
    r = $urandom;
    first_byte = r[7:0];
    bus_write(io_map_pkg::uart_base, {24'h0, first_byte}, 4'b0001);
    bus_write(io_map_pkg::uart_base, {24'h0, r[15:8]}, 4'b0001);
    poll_status(uart_stat, periph_pkg::stat_rx_valid, 1'b1, 100, "uart rx_valid");
    bus_read(io_map_pkg::uart_base, got);
    check_value("uart byte with dropped write", got, {24'h0, first_byte});
    poll_status(uart_stat, periph_pkg::stat_busy, 1'b0, 100, "uart transmitter idle");
    repeat (96) @(posedge clk);  // longer than one frame
    bus_read(uart_stat, got);
    check_value("uart rx_valid after dropped write", {31'h0, got[periph_pkg::stat_rx_valid]}, '0);

    for (int i = 0; i < 4; i++) begin
      r = $urandom;
      bus_write(io_map_pkg::spi_base, {24'h0, r[7:0]}, 4'b0001);
      poll_status(spi_stat, periph_pkg::stat_busy, 1'b0, 50, "spi transfer end");
      bus_read(io_map_pkg::spi_base, got);
      check_value("spi loopback byte", got, {24'h0, r[7:0]});
    end

    r = $urandom;
    sel = r[7:0];
    bus_write(spi_stat, {16'h0, sel, 8'h00}, 4'b0010);
    @(negedge clk);
    check_value("spi_selects after load", {24'h0, spi_selects}, {24'h0, sel});
    bus_write(spi_stat, {16'h0, ~sel, 8'h00}, 4'b1101);  // lane 1 off
    @(negedge clk);
    check_value("spi_selects with be[1] clear", {24'h0, spi_selects}, {24'h0, sel});
    bus_read(spi_stat, got);
    check_value("spi selects readback", {24'h0, got[15:8]}, {24'h0, sel});

    repeat (4) @(posedge clk);
    errors = errors + i_dut.u_checker.fail_cnt;
    $display("checks %0d, errors %0d (assertion failures %0d)",
             checks, errors, i_dut.u_checker.fail_cnt);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* bench/io_subsystem_checker.sv */
`timescale 1ns/1ns

module io_subsystem_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              read,
  input logic              write,
  input io_map_pkg::addr_t address,
  input io_map_pkg::word_t data_out,
  input logic              wait_out,
  input logic              interrupt,
  input logic              tx0,
  input logic              sclk,
  input logic              mosi,
  input logic [7:0]        spi_selects
);

  localparam io_map_pkg::addr_t uart_stat = io_map_pkg::uart_base + 11'd4;
  localparam io_map_pkg::addr_t spi_stat  = io_map_pkg::spi_base + 11'd4;

  int fail_cnt = 0;  // read by the testbench at the end

  // ########################################
  // bus wait protocol
  // ########################################

  a_wait_first : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(read || write) |-> wait_out)
    else begin fail_cnt++; $error("wait_out low in the first cycle of an access"); end

  a_wait_second : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(read || write) |=> !wait_out)
    else begin fail_cnt++; $error("wait_out still high in the second cycle of an access"); end

  a_wait_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (!(read || write) && !$past(read || write)) |-> wait_out)
    else begin fail_cnt++; $error("wait_out low with no access on the bus"); end

  // ########################################
  // reset values and peripheral status
  // ########################################

  a_reset_vals : assert property (@(posedge clk)
    $rose(rst_n) |-> (wait_out && !interrupt && tx0 && !sclk && !mosi && spi_selects == 8'hff))
    else begin fail_cnt++; $error("outputs not at their reset values after reset"); end

  a_irq_status : assert property (@(posedge clk) disable iff (!rst_n)
    (read && address == uart_stat) |-> (interrupt == data_out[periph_pkg::stat_rx_valid]))
    else begin fail_cnt++; $error("interrupt differs from the uart rx_valid status bit"); end

  a_sclk_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (read && address == spi_stat && !data_out[periph_pkg::stat_busy]) |-> !sclk)
    else begin fail_cnt++; $error("sclk high while the spi master reports not busy"); end

endmodule

bind io_subsystem io_subsystem_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .read        (read),
  .write       (write),
  .address     (address),
  .data_out    (data_out),
  .wait_out    (wait_out),
  .interrupt   (interrupt),
  .tx0         (tx0),
  .sclk        (sclk),
  .mosi        (mosi),
  .spi_selects (spi_selects)
);

/* logic/io_subsystem.sv */
`timescale 1ns/1ns

module io_subsystem #(
  parameter int clks_per_bit = 8,
  parameter int sclk_div     = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              read,
  input  logic              write,
  input  io_map_pkg::addr_t address,
  input  io_map_pkg::word_t data_in,
  input  io_map_pkg::be_t   be,
  input  logic [15:0]       sw,
  input  logic [3:0]        kbd,
  input  logic              rx0,
  input  logic              miso,
  output io_map_pkg::word_t data_out,
  output logic              wait_out,
  output logic              tx0,
  output logic              sclk,
  output logic              mosi,
  output logic [7:0]        spi_selects,
  output logic              interrupt
);

  logic              uart_read;
  logic              uart_write;
  logic              spi_read;
  logic              spi_write;
  logic              done;
  io_map_pkg::word_t uart_rdata;
  io_map_pkg::word_t spi_rdata;

  io_decoder u_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .read       (read),
    .write      (write),
    .address    (address),
    .sw         (sw),
    .kbd        (kbd),
    .uart_rdata (uart_rdata),
    .spi_rdata  (spi_rdata),
    .uart_read  (uart_read),
    .uart_write (uart_write),
    .spi_read   (spi_read),
    .spi_write  (spi_write),
    .done       (done),
    .data_out   (data_out),
    .wait_out   (wait_out)
  );

  uart_port #(
    .clks_per_bit (clks_per_bit)
  ) u_uart (
    .clk        (clk),
    .rst_n      (rst_n),
    .uart_read  (uart_read),
    .uart_write (uart_write),
    .done       (done),
    .reg_sel    (address[2]),  // word select inside the window
    .be         (be),
    .data_in    (data_in),
    .rdata      (uart_rdata),
    .tx         (tx0),
    .rx         (rx0),
    .interrupt  (interrupt)
  );

  spi_port #(
    .sclk_div (sclk_div)
  ) u_spi (
    .clk         (clk),
    .rst_n       (rst_n),
    .spi_read    (spi_read),
    .spi_write   (spi_write),
    .done        (done),
    .reg_sel     (address[2]),
    .be          (be),
    .data_in     (data_in),
    .rdata       (spi_rdata),
    .sclk        (sclk),
    .mosi        (mosi),
    .miso        (miso),
    .spi_selects (spi_selects)
  );

endmodule

/* logic/io_decoder.sv */
`timescale 1ns/1ns

module io_decoder (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              read,
  input  logic              write,
  input  io_map_pkg::addr_t address,
  input  logic [15:0]       sw,
  input  logic [3:0]        kbd,
  input  io_map_pkg::word_t uart_rdata,
  input  io_map_pkg::word_t spi_rdata,
  output logic              uart_read,
  output logic              uart_write,
  output logic              spi_read,
  output logic              spi_write,
  output logic              done,
  output io_map_pkg::word_t data_out,
  output logic              wait_out
);

  logic [1:0]        iodelay;
  logic              access;
  logic              hit_uart;
  logic              hit_input;
  logic              hit_spi;
  io_map_pkg::word_t input_word;

  // single compare, a below base wraps to a large offset
  function automatic logic in_window(io_map_pkg::addr_t a,
                                     io_map_pkg::addr_t base,
                                     io_map_pkg::addr_t last);
    io_map_pkg::addr_t off;
    off = a - base;
    return off <= io_map_pkg::addr_t'(last - base);
  endfunction

  assign access = read | write;

  // ########################################
  // wait generation
  // ########################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iodelay <= 2'b11;
    end else if (access) begin
      iodelay <= {iodelay[0], 1'b0};
    end else begin
      iodelay <= 2'b11;
    end
  end

  assign wait_out = iodelay[0];
  assign done     = access & iodelay[1] & ~iodelay[0];  // one pulse per access

  // ########################################
  // decode and read mux
  // ########################################

  assign hit_uart  = in_window(address, io_map_pkg::uart_base, io_map_pkg::uart_last);
  assign hit_input = in_window(address, io_map_pkg::input_base, io_map_pkg::input_last);
  assign hit_spi   = in_window(address, io_map_pkg::spi_base, io_map_pkg::spi_last);

  assign uart_read  = read & hit_uart;
  assign uart_write = write & hit_uart;
  assign spi_read   = read & hit_spi;
  assign spi_write  = write & hit_spi;

  assign input_word = {12'h000, ~kbd, sw};  // keypad is active low

  always_comb begin
    data_out = '0;
    if (hit_uart) begin
      data_out = uart_rdata;
    end else if (hit_input && read) begin
      data_out = input_word;
    end else if (hit_spi) begin
      data_out = spi_rdata;
    end
  end

endmodule

/* logic/spi_port.sv */
`timescale 1ns/1ns

module spi_port #(
  parameter int sclk_div = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              spi_read,
  input  logic              spi_write,
  input  logic              done,
  input  logic              reg_sel,
  input  io_map_pkg::be_t   be,
  input  io_map_pkg::word_t data_in,
  output io_map_pkg::word_t rdata,
  output logic              sclk,
  output logic              mosi,
  input  logic              miso,
  output logic [7:0]        spi_selects
);

  localparam int cnt_w = (sclk_div > 1) ? $clog2(sclk_div) : 1;

  typedef logic [cnt_w-1:0] cnt_t;

  localparam cnt_t half_end = cnt_t'(sclk_div - 1);

  periph_pkg::spi_state_t state;
  cnt_t                   div_cnt;
  logic [2:0]             bit_cnt;
  periph_pkg::byte_t      tx_shift;
  periph_pkg::byte_t      rx_shift;
  periph_pkg::byte_t      rx_data;
  logic                   start;
  logic                   sel_load;
  logic                   half_tick;
  logic                   rise;
  logic                   fall;
  logic                   last_fall;
  logic                   busy;
  io_map_pkg::word_t      status;

  assign busy      = (state == periph_pkg::spi_shift);
  assign start     = done & spi_write & ~reg_sel & be[0] & (state == periph_pkg::spi_idle);
  assign sel_load  = done & spi_write & reg_sel & be[1];
  assign half_tick = busy && (div_cnt == half_end);
  assign rise      = half_tick & ~sclk;
  assign fall      = half_tick & sclk;
  assign last_fall = fall & (bit_cnt == 3'd7);

  // ########################################
  // mode 0 shift engine
  // ########################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= periph_pkg::spi_idle;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
    end else begin
      case (state)
        periph_pkg::spi_idle: begin
          if (start) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            mosi    <= data_in[periph_pkg::byte_w-1];  // msb ahead of first rise
            state   <= periph_pkg::spi_shift;
          end
        end
        periph_pkg::spi_shift: begin
          div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
          if (half_tick) begin
            sclk <= ~sclk;
          end
          if (fall) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (last_fall) begin
              state <= periph_pkg::spi_done;
            end else begin
              mosi <= tx_shift[periph_pkg::byte_w-2];
            end
          end
        end
        periph_pkg::spi_done: begin
          mosi  <= 1'b0;
          state <= periph_pkg::spi_idle;
        end
        default: begin
          state <= periph_pkg::spi_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      tx_shift <= data_in[periph_pkg::byte_w-1:0];
    end else if (fall) begin
      tx_shift <= {tx_shift[periph_pkg::byte_w-2:0], 1'b0};
    end
    if (rise) begin
      rx_shift <= {rx_shift[periph_pkg::byte_w-2:0], miso};  // sample on rising edge
    end
    if (last_fall) begin
      rx_data <= rx_shift;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spi_selects <= 8'hff;  // all deselected
    end else if (sel_load) begin
      spi_selects <= data_in[periph_pkg::sel_lsb +: 8];
    end
  end

  always_comb begin
    status = '0;
    status[periph_pkg::stat_busy]   = busy;
    status[periph_pkg::sel_lsb +: 8] = spi_selects;
  end

  always_comb begin
    rdata = '0;
    if (spi_read) begin
      rdata = reg_sel ? status : io_map_pkg::word_t'(rx_data);
    end
  end

endmodule

/* logic/uart_port.sv */
`timescale 1ns/1ns

module uart_port #(
  parameter int clks_per_bit = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              uart_read,
  input  logic              uart_write,
  input  logic              done,
  input  logic              reg_sel,
  input  io_map_pkg::be_t   be,
  input  io_map_pkg::word_t data_in,
  output io_map_pkg::word_t rdata,
  output logic              tx,
  input  logic              rx,
  output logic              interrupt
);

  localparam int cnt_w   = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int half_m1 = (clks_per_bit > 1) ? clks_per_bit / 2 - 1 : 0;

  typedef logic [cnt_w-1:0] cnt_t;

  localparam cnt_t bit_end  = cnt_t'(clks_per_bit - 1);
  localparam cnt_t half_end = cnt_t'(half_m1);

  periph_pkg::uart_state_t tx_state;
  periph_pkg::uart_state_t rx_state;
  cnt_t                    tx_cnt;
  cnt_t                    rx_cnt;
  logic [2:0]              tx_bit;
  logic [2:0]              rx_bit;
  periph_pkg::byte_t       tx_byte;
  periph_pkg::byte_t       rx_shift;
  periph_pkg::byte_t       rx_data;
  logic                    tx_load;
  logic                    tx_tick;
  logic                    rx_tick;
  logic                    rx_store;
  logic                    rx_clear;
  logic                    rx_meta;
  logic                    rx_sync;
  logic                    rx_valid;
  io_map_pkg::word_t       status;

  assign tx_load  = done & uart_write & ~reg_sel & be[0] & (tx_state == periph_pkg::uart_idle);
  assign rx_clear = done & uart_read & ~reg_sel;  // completed data read
  assign tx_tick  = (tx_cnt == bit_end);
  assign rx_tick  = (rx_cnt == bit_end);
  assign rx_store = (rx_state == periph_pkg::uart_stop) & rx_tick & rx_sync;

  // ########################################
  // transmitter
  // ########################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= periph_pkg::uart_idle;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx       <= 1'b1;
    end else begin
      if (tx_state != periph_pkg::uart_idle) begin
        tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
      end
      case (tx_state)
        periph_pkg::uart_idle: begin
          if (tx_load) begin
            tx       <= 1'b0;  // start bit
            tx_cnt   <= '0;
            tx_state <= periph_pkg::uart_start;
          end
        end
        periph_pkg::uart_start: begin
          if (tx_tick) begin
            tx_bit   <= '0;
            tx       <= tx_byte[0];
            tx_state <= periph_pkg::uart_data;
          end
        end
        periph_pkg::uart_data: begin
          if (tx_tick) begin
            if (tx_bit == 3'd7) begin
              tx       <= 1'b1;  // stop bit
              tx_state <= periph_pkg::uart_stop;
            end else begin
              tx_bit <= tx_bit + 3'd1;
              tx     <= tx_byte[tx_bit + 3'd1];
            end
          end
        end
        default: begin
          if (tx_tick) begin
            tx_state <= periph_pkg::uart_idle;
          end
        end
      endcase
    end
  end

  // ########################################
  // receiver
  // ########################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= periph_pkg::uart_idle;
      rx_cnt   <= '0;
      rx_bit   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (rx_clear) begin
        rx_valid <= 1'b0;
      end
      case (rx_state)
        periph_pkg::uart_idle: begin
          rx_cnt <= '0;
          if (!rx_sync) begin
            rx_state <= periph_pkg::uart_start;
          end
        end
        periph_pkg::uart_start: begin
          if (rx_cnt == half_end) begin  // middle of start bit
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_state <= rx_sync ? periph_pkg::uart_idle : periph_pkg::uart_data;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        periph_pkg::uart_data: begin
          rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
          if (rx_tick) begin
            rx_bit <= rx_bit + 3'd1;
            if (rx_bit == 3'd7) begin
              rx_state <= periph_pkg::uart_stop;
            end
          end
        end
        default: begin
          rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
          if (rx_tick) begin
            rx_state <= periph_pkg::uart_idle;
          end
          if (rx_store) begin
            rx_valid <= 1'b1;  // new byte beats a clear
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_byte <= data_in[periph_pkg::byte_w-1:0];
    end
    if ((rx_state == periph_pkg::uart_data) && rx_tick) begin
      rx_shift[rx_bit] <= rx_sync;  // lsb first
    end
    if (rx_store) begin
      rx_data <= rx_shift;
    end
  end

  always_comb begin
    status = '0;
    status[periph_pkg::stat_busy]     = (tx_state != periph_pkg::uart_idle);
    status[periph_pkg::stat_rx_valid] = rx_valid;
  end

  always_comb begin
    rdata = '0;
    if (uart_read) begin
      rdata = reg_sel ? status : io_map_pkg::word_t'(rx_data);
    end
  end

  assign interrupt = rx_valid;

endmodule

/* logic/periph_pkg.sv */
package periph_pkg;

  localparam int byte_w = 8;

  typedef logic [byte_w-1:0] byte_t;

  // ########################################
  // status word layout
  // ########################################

  localparam int stat_busy     = 0;
  localparam int stat_rx_valid = 1;  // uart only
  localparam int sel_lsb       = 8;  // spi selects live in 15:8

  // ########################################
  // state machines
  // ########################################

  typedef enum logic [1:0] {
    uart_idle,
    uart_start,
    uart_data,
    uart_stop
  } uart_state_t;

  typedef enum logic [1:0] {
    spi_idle,
    spi_shift,
    spi_done
  } spi_state_t;

endpackage

/* logic/io_map_pkg.sv */
package io_map_pkg;

  localparam int addr_w = 11;
  localparam int data_w = 32;
  localparam int be_w   = data_w / 8;

  typedef logic [addr_w-1:0] addr_t;  // byte address in the i/o window
  typedef logic [data_w-1:0] word_t;
  typedef logic [be_w-1:0]   be_t;

  // ########################################
  // address map, inclusive byte ranges
  // ########################################

  localparam addr_t uart_base  = 11'h000;
  localparam addr_t uart_last  = 11'h007;  // data, status

  localparam addr_t input_base = 11'h010;
  localparam addr_t input_last = 11'h013;  // switches and keypad

  localparam addr_t spi_base   = 11'h020;
  localparam addr_t spi_last   = 11'h027;  // data, selects/status

endpackage
